// File: Bender.yml
package:
  name: raven_io

sources:
  - verilog/soc_map_pkg.sv
  - verilog/pad_cfg_pkg.sv
  - verilog/mem_bus_router.sv
  - verilog/io_ctrl_regs.sv
  - verilog/pad_mux.sv
  - verilog/irq_router.sv
  - verilog/raven_io_top.sv
  - target: test
    files:
      - test/tb_raven_io.sv

// File: all.f
verilog/soc_map_pkg.sv
verilog/pad_cfg_pkg.sv
verilog/mem_bus_router.sv
verilog/io_ctrl_regs.sv
verilog/pad_mux.sv
verilog/irq_router.sv
verilog/raven_io_top.sv
test/tb_raven_io.sv

// File: test/tb_raven_io.sv
`default_nettype none

module tb_raven_io
	import soc_map_pkg::*;
	import pad_cfg_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam integer MEM_WORDS = 1024;
	localparam integer RAM_AW = $clog2(MEM_WORDS);
	// Transactions per test
	localparam integer N_WR = 200;
	localparam integer N_RAM = 100;
	localparam integer N_PAD = 40;
	localparam integer N_IRQ = 40;
	// Three cycles per bus transfer, plus setup cycles per loop pass
	localparam integer RUN_CYCLES = 3 + 3 * (64 + N_WR + 64 + N_RAM)
		+ N_PAD * (3 * 9 + 2) + N_IRQ * (3 * 4 + 2);
	localparam integer TIMEOUT = 2 * RUN_CYCLES;

	logic clk;
	logic resetn;
	mem_req_t mem_req;
	mem_rsp_t mem_rsp;
	logic ram_wenb;
	logic [RAM_AW-1:0] ram_addr;
	word_t ram_wdata;
	word_t ram_rdata;
	pad_word_t gpio_in;
	pad_word_t gpio_out;
	pad_word_t gpio_outenb;
	pad_word_t gpio_pullup;
	pad_word_t gpio_pulldown;
	analog_mon_t mon;
	spi_ro_t spi_ro;
	analog_ctrl_t analog_ctrl;
	logic irq_pin;
	logic irq_spi;
	word_t irq;

	// Shadow of the writable registers, one entry per word offset
	logic [15:0] shadow [0:63];
	word_t rng = 32'd90;
	integer errors = 0;
	integer checks = 0;
	integer cycle_cnt = 0;
	// SRAM pins in the first cycle of a request
	logic first_wenb;
	logic [RAM_AW-1:0] first_addr;
	word_t first_wdata;

	raven_io_top #(
		.MEM_WORDS(MEM_WORDS)
	) UUT (
		.clk(clk),
		.resetn(resetn),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp),
		.ram_wenb(ram_wenb),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata),
		.gpio_in(gpio_in),
		.gpio_out(gpio_out),
		.gpio_outenb(gpio_outenb),
		.gpio_pullup(gpio_pullup),
		.gpio_pulldown(gpio_pulldown),
		.mon(mon),
		.spi_ro(spi_ro),
		.analog_ctrl(analog_ctrl),
		.irq_pin(irq_pin),
		.irq_spi(irq_spi),
		.irq(irq)
	);

	always #5 clk = ~clk;

	// Run limit
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT) begin
			$display("timeout: run did not end within %0d cycles", TIMEOUT);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// LCG, two steps per word, upper halves only
	function automatic word_t rand32();
		word_t hi;
		rng = rng * 32'd1664525 + 32'd1013904223;
		hi = rng;
		rng = rng * 32'd1664525 + 32'd1013904223;
		return {hi[31:16], rng[31:16]};
	endfunction

	// Writable bits of each offset
	function automatic logic [15:0] wr_mask(input logic [7:0] off);
		case (off)
			GPIO_DATA, GPIO_OEB, GPIO_PU, GPIO_PD:
				return 16'hffff;
			COMP_ENA, RCOSC_ENA, ANALOG_SEL, OPAMP_BIAS, OPAMP_ENA, BG_ENA,
			OVERTEMP_ENA:
				return 16'h0001;
			COMP_NSRC, COMP_PSRC, COMP_DEST, RCOSC_DEST, XTAL_DEST, TRAP_DEST,
			IRQ7_SRC, IRQ8_SRC, OVERTEMP_DEST:
				return 16'h0003;
			default:
				return 16'h0000;
		endcase
	endfunction

	function automatic logic [15:0] sh16(input logic [7:0] off);
		return shadow[off[7:2]];
	endfunction

	function automatic logic [1:0] sh2(input logic [7:0] off);
		logic [15:0] v;
		v = shadow[off[7:2]];
		return v[1:0];
	endfunction

	function automatic logic sh1(input logic [7:0] off);
		logic [15:0] v;
		v = shadow[off[7:2]];
		return v[0];
	endfunction

	// All zero, pads start as inputs
	task automatic model_reset();
		logic [7:0] o;
		for (int i = 0; i < 64; i++)
			shadow[i] = 16'h0000;
		o = GPIO_OEB;
		shadow[o[7:2]] = 16'hffff;
	endtask

	// Lane 0 for bits 7:0, lane 1 for bits 15:8 of GPIO words
	task automatic model_write(input logic [7:0] off, input word_t wdata, input strb_t strb);
		logic [15:0] m;
		m = wr_mask(off);
		if (strb[0])
			shadow[off[7:2]][7:0] = wdata[7:0] & m[7:0];
		if (strb[1])
			shadow[off[7:2]][15:8] = wdata[15:8] & m[15:8];
	endtask

	function automatic pad_cfg_t model_cfg();
		pad_cfg_t c;
		c.data = sh16(GPIO_DATA);
		c.oeb = sh16(GPIO_OEB);
		c.pu = sh16(GPIO_PU);
		c.pd = sh16(GPIO_PD);
		c.comp_dest = route_e'(sh2(COMP_DEST));
		c.rcosc_dest = route_e'(sh2(RCOSC_DEST));
		c.xtal_dest = route_e'(sh2(XTAL_DEST));
		c.trap_dest = route_e'(sh2(TRAP_DEST));
		c.overtemp_dest = route_e'(sh2(OVERTEMP_DEST));
		c.irq7_src = irq_src_e'(sh2(IRQ7_SRC));
		c.irq8_src = irq_src_e'(sh2(IRQ8_SRC));
		return c;
	endfunction

	function automatic analog_ctrl_t model_ana();
		analog_ctrl_t a;
		a.comp_ena = sh1(COMP_ENA);
		a.comp_ninputsrc = sh2(COMP_NSRC);
		a.comp_pinputsrc = sh2(COMP_PSRC);
		a.rcosc_ena = sh1(RCOSC_ENA);
		a.overtemp_ena = sh1(OVERTEMP_ENA);
		a.analog_out_sel = sh1(ANALOG_SEL);
		a.opamp_ena = sh1(OPAMP_ENA);
		a.opamp_bias_ena = sh1(OPAMP_BIAS);
		a.bg_ena = sh1(BG_ENA);
		return a;
	endfunction

	// Pad groups that keep their oeb, pu and pd bits
	function automatic pad_word_t exp_keep(input pad_cfg_t c);
		pad_word_t k;
		k = '1;
		if (c.comp_dest != ROUTE_OFF)
			k[1:0] = 2'b00;
		if (c.rcosc_dest != ROUTE_OFF)
			k[4:2] = 3'b000;
		if (c.xtal_dest != ROUTE_OFF)
			k[7:5] = 3'b000;
		if (c.trap_dest != ROUTE_OFF)
			k[13:11] = 3'b000;
		if (c.overtemp_dest != ROUTE_OFF)
			k[15:14] = 2'b00;
		return k;
	endfunction

	// Data bits with selected monitor pads replaced
	function automatic pad_word_t exp_out(input pad_cfg_t c, input analog_mon_t m);
		pad_word_t o;
		o = c.data;
		if (c.comp_dest == ROUTE_A)
			o[0] = m.comp_in;
		else if (c.comp_dest == ROUTE_B)
			o[1] = m.comp_in;
		// A, B, C map onto consecutive pads
		if (c.rcosc_dest != ROUTE_OFF)
			o[1 + int'(c.rcosc_dest)] = m.rcosc_in;
		if (c.xtal_dest != ROUTE_OFF)
			o[4 + int'(c.xtal_dest)] = m.xtal_in;
		if (c.trap_dest != ROUTE_OFF)
			o[10 + int'(c.trap_dest)] = m.trap;
		if (c.overtemp_dest == ROUTE_A)
			o[14] = m.overtemp;
		else if (c.overtemp_dest == ROUTE_B)
			o[15] = m.overtemp;
		return o;
	endfunction

	function automatic word_t exp_irq(input pad_cfg_t c, input pad_word_t gin,
		input analog_mon_t m, input logic pin, input logic spi);
		word_t v;
		v = '0;
		v[5] = pin;
		v[6] = spi;
		if (c.irq7_src != IRQ_OFF)
			v[7] = gin[int'(c.irq7_src) - 1];
		if (c.irq8_src != IRQ_OFF)
			v[8] = gin[int'(c.irq8_src) + 2];
		v[9] = (c.comp_dest == ROUTE_C) & m.comp_in;
		v[10] = (c.overtemp_dest == ROUTE_C) & m.overtemp;
		return v;
	endfunction

	// Expected read data of one offset
	function automatic word_t model_read(input logic [7:0] off);
		case (off)
			GPIO_DATA:   return {exp_out(model_cfg(), mon), gpio_in};
			SPI_CONFIG:  return {24'd0, spi_ro.cfg};
			SPI_OSC:     return {30'd0, spi_ro.xtal_ena, spi_ro.reg_ena};
			SPI_PLL:     return {25'd0, spi_ro.pll_trim, spi_ro.pll_cp_ena,
				spi_ro.pll_vco_ena, spi_ro.pll_bias_ena};
			MFGR_ID:     return {20'd0, spi_ro.mfgr_id};
			PROD_ID:     return {24'd0, spi_ro.prod_id};
			MASK_REV:    return {28'd0, spi_ro.mask_rev};
			OVERTEMP_IN: return {31'd0, mon.overtemp};
			// Unmapped offsets stay zero in the shadow
			default:     return {16'd0, sh16(off)};
		endcase
	endfunction

	task automatic report_failure(input string msg);
		errors = errors + 1;
		$display("%s", msg);
	endtask

	task automatic check_rsp(input string name, input mem_rsp_t got, input word_t exp);
		checks = checks + 1;
		if (got.rdata !== exp) begin
			errors = errors + 1;
			$display("mismatch %s: got 0x%08h expected 0x%08h", name, got.rdata, exp);
		end
	endtask

	task automatic check_pad(input string name, input pad_word_t got, input pad_word_t exp);
		checks = checks + 1;
		if (got !== exp) begin
			errors = errors + 1;
			$display("mismatch %s: got 0x%04h expected 0x%04h", name, got, exp);
		end
	endtask

	task automatic check_ana(input analog_ctrl_t got, input analog_ctrl_t exp);
		checks = checks + 1;
		if (got !== exp) begin
			errors = errors + 1;
			$display("mismatch analog_ctrl: got 0x%03h expected 0x%03h", got, exp);
		end
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks = checks + 1;
		if (got !== exp) begin
			errors = errors + 1;
			$display("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
		end
	endtask

	// One bus transfer, returns at the falling edge after valid drops
	task automatic bus_xfer(input word_t addr, input word_t wdata, input strb_t strb,
		input word_t sram_word, output mem_rsp_t rsp, output integer lat);
		integer waits;
		@(posedge clk);
		mem_req.valid <= 1'b1;
		mem_req.addr <= addr;
		mem_req.wdata <= wdata;
		mem_req.wstrb <= strb;
		ram_rdata <= sram_word;
		waits = 0;
		// Outputs sampled mid-cycle
		do begin
			@(negedge clk);
			waits = waits + 1;
			if (waits == 1) begin
				first_wenb = ram_wenb;
				first_addr = ram_addr;
				first_wdata = ram_wdata;
			end
		end while (mem_rsp.ready !== 1'b1);
		rsp = mem_rsp;
		lat = waits - 1;
		@(posedge clk);
		mem_req.valid <= 1'b0;
		@(negedge clk);
	endtask

	task automatic io_write(input logic [7:0] off, input word_t wdata, input strb_t strb);
		mem_rsp_t rsp;
		integer lat;
		bus_xfer({IO_BASE, off}, wdata, strb, 32'd0, rsp, lat);
		model_write(off, wdata, strb);
	endtask

	task automatic io_read(input logic [7:0] off);
		mem_rsp_t rsp;
		integer lat;
		bus_xfer({IO_BASE, off}, 32'd0, 4'h0, 32'd0, rsp, lat);
		check_rsp($sformatf("mem_rsp.rdata at 0x%02h", off), rsp, model_read(off));
	endtask

	task automatic end_test(input string name, input integer err0);
		if (errors == err0)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - err0);
	endtask

	initial begin
		word_t r;
		word_t wd;
		word_t widx;
		word_t sram;
		strb_t st;
		logic [63:0] r64;
		mem_rsp_t rsp;
		integer lat;
		integer err0;
		pad_cfg_t c;

		clk = 1'b0;
		resetn = 1'b0;
		mem_req = '0;
		ram_rdata = '0;
		gpio_in = '0;
		mon = '0;
		spi_ro = '0;
		irq_pin = 1'b0;
		irq_spi = 1'b0;
		model_reset();
		repeat (3) @(posedge clk);
		resetn <= 1'b1;

		// Reset values
		err0 = errors;
		@(negedge clk);
		check_pad("gpio_outenb", gpio_outenb, 16'hffff);
		check_ana(analog_ctrl, '0);
		if (mem_rsp.ready !== 1'b0 || ram_wenb !== 1'b1)
			report_failure("bus outputs not idle after reset");
		for (int i = 0; i < 64; i++)
			io_read(8'(i * 4));
		end_test("reset values", err0);

		// Random control register traffic
		err0 = errors;
		r64 = {rand32(), rand32()};
		r = rand32();
		@(posedge clk);
		spi_ro <= r64[44:0];
		gpio_in <= r64[60:45];
		mon <= r[4:0];
		for (int i = 0; i < N_WR; i++) begin
			r = rand32();
			io_write({r[5:0], 2'b00}, rand32(), r[11:8]);
			check_ana(analog_ctrl, model_ana());
		end
		for (int i = 0; i < 64; i++)
			io_read(8'(i * 4));
		end_test("control registers", err0);

		// Scratchpad window
		err0 = errors;
		for (int i = 0; i < N_RAM; i++) begin
			r = rand32();
			widx = r % MEM_WORDS;
			wd = rand32();
			// Reads carry no strobes
			st = r[31] ? r[19:16] : 4'h0;
			sram = rand32();
			bus_xfer(widx << 2, wd, st, sram, rsp, lat);
			check_word("ram_addr", word_t'(first_addr), widx);
			check_word("ram_wdata", first_wdata, wd);
			if (first_wenb !== (st == 4'h0))
				report_failure("ram_wenb did not follow the write strobes");
			if (lat != 1)
				report_failure($sformatf("RAM ready came %0d cycles after valid", lat));
			check_rsp("mem_rsp.rdata", rsp, sram);
		end
		end_test("ram window", err0);

		// Monitor routing onto the pads
		err0 = errors;
		for (int i = 0; i < N_PAD; i++) begin
			r = rand32();
			@(posedge clk);
			mon <= r[4:0];
			io_write(GPIO_DATA, rand32(), 4'hf);
			io_write(GPIO_OEB, rand32(), 4'hf);
			io_write(GPIO_PU, rand32(), 4'hf);
			io_write(GPIO_PD, rand32(), 4'hf);
			r = rand32();
			io_write(COMP_DEST, r, 4'h1);
			io_write(RCOSC_DEST, r >> 2, 4'h1);
			io_write(XTAL_DEST, r >> 4, 4'h1);
			io_write(TRAP_DEST, r >> 6, 4'h1);
			io_write(OVERTEMP_DEST, r >> 8, 4'h1);
			c = model_cfg();
			check_pad("gpio_out", gpio_out, exp_out(c, mon));
			check_pad("gpio_outenb", gpio_outenb, c.oeb & exp_keep(c));
			check_pad("gpio_pullup", gpio_pullup, c.pu & exp_keep(c));
			check_pad("gpio_pulldown", gpio_pulldown, c.pd & exp_keep(c));
		end
		end_test("pad routing", err0);

		// IRQ vector
		err0 = errors;
		for (int i = 0; i < N_IRQ; i++) begin
			r = rand32();
			io_write(IRQ7_SRC, r, 4'h1);
			io_write(IRQ8_SRC, r >> 2, 4'h1);
			io_write(COMP_DEST, r >> 4, 4'h1);
			io_write(OVERTEMP_DEST, r >> 6, 4'h1);
			r64 = {rand32(), rand32()};
			@(posedge clk);
			gpio_in <= r64[15:0];
			mon <= r64[20:16];
			irq_pin <= r64[21];
			irq_spi <= r64[22];
			@(negedge clk);
			check_word("irq", irq, exp_irq(model_cfg(), gpio_in, mon, irq_pin, irq_spi));
		end
		end_test("irq vector", err0);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/io_ctrl_regs.sv
`default_nettype none

module io_ctrl_regs
	import soc_map_pkg::*;
	import pad_cfg_pkg::*;
(
	input wire clk,
	input wire resetn,
	input wire mem_req_t io_req,
	output mem_rsp_t io_rsp,
	input wire pad_word_t gpio_in,
	input wire pad_word_t gpio_out,
	input wire analog_mon_t mon,
	input wire spi_ro_t spi_ro,
	output pad_cfg_t pad_cfg,
	output analog_ctrl_t analog_ctrl
);

	pad_cfg_t cfg_q;
	analog_ctrl_t ana_q;
	reg_offset_e offset;
	logic req_hit;
	logic wr_lane0;
	logic rsp_ready;
	word_t rsp_rdata;
	word_t rd_mux;

	// Byte lanes 0 and 1 of a 16-bit GPIO register
	function automatic pad_word_t wr_pad(input pad_word_t cur, input word_t wdata,
		input strb_t wstrb);
		pad_word_t nxt;
		nxt = cur;
		if (wstrb[0])
			nxt[7:0] = wdata[7:0];
		if (wstrb[1])
			nxt[15:8] = wdata[15:8];
		return nxt;
	endfunction

	assign offset = reg_offset_e'(io_req.addr[7:0]);
	// Take a new request only when not acking the previous one
	assign req_hit = io_req.valid && !rsp_ready;
	assign wr_lane0 = io_req.wstrb[0];

	// Readback, zero extended
	always_comb begin
		rd_mux = '0;
		case (offset)
			GPIO_DATA:     rd_mux = {gpio_out, gpio_in};
			GPIO_OEB:      rd_mux = {16'd0, cfg_q.oeb};
			GPIO_PU:       rd_mux = {16'd0, cfg_q.pu};
			GPIO_PD:       rd_mux = {16'd0, cfg_q.pd};
			COMP_ENA:      rd_mux = {31'd0, ana_q.comp_ena};
			COMP_NSRC:     rd_mux = {30'd0, ana_q.comp_ninputsrc};
			COMP_PSRC:     rd_mux = {30'd0, ana_q.comp_pinputsrc};
			COMP_DEST:     rd_mux = {30'd0, cfg_q.comp_dest};
			RCOSC_ENA:     rd_mux = {31'd0, ana_q.rcosc_ena};
			RCOSC_DEST:    rd_mux = {30'd0, cfg_q.rcosc_dest};
			// SPI side values, never written from here
			SPI_CONFIG:    rd_mux = {24'd0, spi_ro.cfg};
			SPI_OSC:       rd_mux = {30'd0, spi_ro.xtal_ena, spi_ro.reg_ena};
			SPI_PLL:       rd_mux = {25'd0, spi_ro.pll_trim, spi_ro.pll_cp_ena,
				spi_ro.pll_vco_ena, spi_ro.pll_bias_ena};
			MFGR_ID:       rd_mux = {20'd0, spi_ro.mfgr_id};
			PROD_ID:       rd_mux = {24'd0, spi_ro.prod_id};
			MASK_REV:      rd_mux = {28'd0, spi_ro.mask_rev};
			XTAL_DEST:     rd_mux = {30'd0, cfg_q.xtal_dest};
			TRAP_DEST:     rd_mux = {30'd0, cfg_q.trap_dest};
			IRQ7_SRC:      rd_mux = {30'd0, cfg_q.irq7_src};
			IRQ8_SRC:      rd_mux = {30'd0, cfg_q.irq8_src};
			ANALOG_SEL:    rd_mux = {31'd0, ana_q.analog_out_sel};
			OPAMP_BIAS:    rd_mux = {31'd0, ana_q.opamp_bias_ena};
			OPAMP_ENA:     rd_mux = {31'd0, ana_q.opamp_ena};
			BG_ENA:        rd_mux = {31'd0, ana_q.bg_ena};
			OVERTEMP_ENA:  rd_mux = {31'd0, ana_q.overtemp_ena};
			// Live alarm level
			OVERTEMP_IN:   rd_mux = {31'd0, mon.overtemp};
			OVERTEMP_DEST: rd_mux = {30'd0, cfg_q.overtemp_dest};
			default:       rd_mux = '0;
		endcase
	end

	// Register writes and the single-cycle ready
	always_ff @(posedge clk) begin
		if (!resetn) begin
			rsp_ready <= 1'b0;
			// Pads come up as inputs
			cfg_q <= '{
				data: '0, oeb: '1, pu: '0, pd: '0,
				comp_dest: ROUTE_OFF, rcosc_dest: ROUTE_OFF, xtal_dest: ROUTE_OFF,
				trap_dest: ROUTE_OFF, overtemp_dest: ROUTE_OFF,
				irq7_src: IRQ_OFF, irq8_src: IRQ_OFF
			};
			ana_q <= '0;
		end else begin
			rsp_ready <= req_hit;
			if (req_hit) begin
				case (offset)
					GPIO_DATA: cfg_q.data <= wr_pad(cfg_q.data, io_req.wdata, io_req.wstrb);
					GPIO_OEB:  cfg_q.oeb <= wr_pad(cfg_q.oeb, io_req.wdata, io_req.wstrb);
					GPIO_PU:   cfg_q.pu <= wr_pad(cfg_q.pu, io_req.wdata, io_req.wstrb);
					GPIO_PD:   cfg_q.pd <= wr_pad(cfg_q.pd, io_req.wdata, io_req.wstrb);
					// Everything below uses lane 0 only
					COMP_ENA:
						if (wr_lane0) ana_q.comp_ena <= io_req.wdata[0];
					COMP_NSRC:
						if (wr_lane0) ana_q.comp_ninputsrc <= io_req.wdata[1:0];
					COMP_PSRC:
						if (wr_lane0) ana_q.comp_pinputsrc <= io_req.wdata[1:0];
					COMP_DEST:
						if (wr_lane0) cfg_q.comp_dest <= route_e'(io_req.wdata[1:0]);
					RCOSC_ENA:
						if (wr_lane0) ana_q.rcosc_ena <= io_req.wdata[0];
					RCOSC_DEST:
						if (wr_lane0) cfg_q.rcosc_dest <= route_e'(io_req.wdata[1:0]);
					XTAL_DEST:
						if (wr_lane0) cfg_q.xtal_dest <= route_e'(io_req.wdata[1:0]);
					TRAP_DEST:
						if (wr_lane0) cfg_q.trap_dest <= route_e'(io_req.wdata[1:0]);
					IRQ7_SRC:
						if (wr_lane0) cfg_q.irq7_src <= irq_src_e'(io_req.wdata[1:0]);
					IRQ8_SRC:
						if (wr_lane0) cfg_q.irq8_src <= irq_src_e'(io_req.wdata[1:0]);
					ANALOG_SEL:
						if (wr_lane0) ana_q.analog_out_sel <= io_req.wdata[0];
					OPAMP_BIAS:
						if (wr_lane0) ana_q.opamp_bias_ena <= io_req.wdata[0];
					OPAMP_ENA:
						if (wr_lane0) ana_q.opamp_ena <= io_req.wdata[0];
					BG_ENA:
						if (wr_lane0) ana_q.bg_ena <= io_req.wdata[0];
					OVERTEMP_ENA:
						if (wr_lane0) ana_q.overtemp_ena <= io_req.wdata[0];
					OVERTEMP_DEST:
						if (wr_lane0) cfg_q.overtemp_dest <= route_e'(io_req.wdata[1:0]);
					// Read-only and unmapped offsets ignore writes
					default: ;
				endcase
			end
		end
	end

	// Read data only loads with an accepted request
	always_ff @(posedge clk) begin
		if (req_hit)
			rsp_rdata <= rd_mux;
	end

	assign io_rsp.ready = rsp_ready;
	assign io_rsp.rdata = rsp_rdata;
	assign pad_cfg = cfg_q;
	assign analog_ctrl = ana_q;

	// A pending request stays up until its single ack
	assert property (@(posedge clk) disable iff (!resetn)
		io_req.valid && !io_rsp.ready |=> io_req.valid);

endmodule

`default_nettype wire

// File: verilog/irq_router.sv
`default_nettype none

module irq_router
	import soc_map_pkg::*;
	import pad_cfg_pkg::*;
(
	input wire pad_cfg_t pad_cfg,
	input wire pad_word_t gpio_in,
	input wire analog_mon_t mon,
	input wire irq_pin,
	input wire irq_spi,
	output word_t irq
);

	// One of three pads, or nothing
	function automatic logic pick_pad(input irq_src_e src, input logic [2:0] pads);
		case (src)
			IRQ_PAD_A: return pads[0];
			IRQ_PAD_B: return pads[1];
			IRQ_PAD_C: return pads[2];
			default:   return 1'b0;
		endcase
	endfunction

	always_comb begin
		irq = '0;
		irq[5] = irq_pin;
		irq[6] = irq_spi;
		// IRQ7 from pads 0..2, IRQ8 from pads 3..5
		irq[7] = pick_pad(pad_cfg.irq7_src, gpio_in[2:0]);
		irq[8] = pick_pad(pad_cfg.irq8_src, gpio_in[5:3]);
		// ROUTE_C sends comparator and alarm to the CPU
		irq[9] = (pad_cfg.comp_dest == ROUTE_C) && mon.comp_in;
		irq[10] = (pad_cfg.overtemp_dest == ROUTE_C) && mon.overtemp;
	end

endmodule

`default_nettype wire

// File: verilog/mem_bus_router.sv
`default_nettype none

module mem_bus_router
	import soc_map_pkg::*;
#(
	parameter integer MEM_WORDS = 1024
) (
	input wire clk,
	input wire resetn,
	input wire mem_req_t mem_req,
	output mem_rsp_t mem_rsp,
	output mem_req_t io_req,
	input wire mem_rsp_t io_rsp,
	output logic ram_wenb,
	output logic [$clog2(MEM_WORDS)-1:0] ram_addr,
	output word_t ram_wdata,
	input wire word_t ram_rdata
);

	// Word address width of the scratchpad
	localparam integer RAM_AW = $clog2(MEM_WORDS);
	// First byte address past the scratchpad
	localparam word_t RAM_LIMIT = word_t'(4 * MEM_WORDS);

	logic ram_sel;
	logic io_sel;
	logic ram_ready;

	// Window decode
	assign ram_sel = mem_req.valid && (mem_req.addr < RAM_LIMIT);
	assign io_sel = mem_req.valid && (mem_req.addr[31:8] == IO_BASE);

	// Register file sees valid only inside its window
	always_comb begin
		io_req = mem_req;
		io_req.valid = io_sel;
	end

	// SRAM pins
	// Write enable low while pending, if any lane is written
	assign ram_wenb = (ram_sel && !ram_ready) ? ~|mem_req.wstrb : 1'b1;
	assign ram_addr = mem_req.addr[RAM_AW+1:2];
	assign ram_wdata = mem_req.wdata;

	// SRAM answers one cycle after valid
	// Cleared after a ready so a held request is not acked twice
	always_ff @(posedge clk) begin
		if (!resetn) begin
			ram_ready <= 1'b0;
		end else begin
			ram_ready <= ram_sel && !ram_ready;
		end
	end

	// Merge of the two responders
	always_comb begin
		mem_rsp.ready = io_rsp.ready || ram_ready;
		if (io_rsp.ready)
			mem_rsp.rdata = io_rsp.rdata;
		else if (ram_ready)
			mem_rsp.rdata = ram_rdata;
		else
			mem_rsp.rdata = '0;
	end

	// Ready only ever answers a request that was already pending
	assert property (@(posedge clk) disable iff (!resetn)
		$rose(mem_rsp.ready) |-> mem_req.valid && $past(mem_req.valid));

endmodule

`default_nettype wire

// File: verilog/pad_cfg_pkg.sv
`default_nettype none

package pad_cfg_pkg;

	// Number of GPIO pads
	localparam integer GPIO_W = 16;

	// One bit per pad
	typedef logic [GPIO_W-1:0] pad_word_t;

	// Monitor destination select
	// Which pad of a group carries the monitor signal
	typedef enum logic [1:0] {
		ROUTE_OFF = 2'd0,
		ROUTE_A   = 2'd1,
		ROUTE_B   = 2'd2,
		ROUTE_C   = 2'd3
	} route_e;

	// IRQ input source select
	typedef enum logic [1:0] {
		IRQ_OFF   = 2'd0,
		IRQ_PAD_A = 2'd1,
		IRQ_PAD_B = 2'd2,
		IRQ_PAD_C = 2'd3
	} irq_src_e;

	// Pad side of the register file
	typedef struct packed {
		pad_word_t data;
		// Output enable, active low
		pad_word_t oeb;
		pad_word_t pu;
		pad_word_t pd;
		route_e comp_dest;
		route_e rcosc_dest;
		route_e xtal_dest;
		route_e trap_dest;
		route_e overtemp_dest;
		irq_src_e irq7_src;
		irq_src_e irq8_src;
	} pad_cfg_t;

	// Enables and selects for the analog macros
	typedef struct packed {
		logic comp_ena;
		logic [1:0] comp_ninputsrc;
		logic [1:0] comp_pinputsrc;
		logic rcosc_ena;
		logic overtemp_ena;
		// DAC or bandgap on the analog output
		logic analog_out_sel;
		logic opamp_ena;
		logic opamp_bias_ena;
		logic bg_ena;
	} analog_ctrl_t;

	// Signals that can be routed onto pads
	typedef struct packed {
		logic comp_in;
		logic rcosc_in;
		logic xtal_in;
		logic overtemp;
		logic trap;
	} analog_mon_t;

	// Values set through the standalone SPI, read-only to the CPU
	typedef struct packed {
		logic [7:0] cfg;
		logic xtal_ena;
		logic reg_ena;
		logic pll_cp_ena;
		logic pll_vco_ena;
		logic pll_bias_ena;
		logic [3:0] pll_trim;
		logic [11:0] mfgr_id;
		logic [7:0] prod_id;
		logic [3:0] mask_rev;
	} spi_ro_t;

endpackage

`default_nettype wire

// File: verilog/pad_mux.sv
`default_nettype none

module pad_mux
	import pad_cfg_pkg::*;
(
	input wire pad_cfg_t pad_cfg,
	input wire analog_mon_t mon,
	output pad_word_t gpio_out,
	output pad_word_t gpio_outenb,
	output pad_word_t gpio_pullup,
	output pad_word_t gpio_pulldown
);

	pad_word_t mon_sel;
	pad_word_t mon_val;
	pad_word_t grp_keep;

	// Pad selected by each monitor destination
	// Pads 8 to 10 never carry a monitor
	assign mon_sel = {
		pad_cfg.overtemp_dest == ROUTE_B, pad_cfg.overtemp_dest == ROUTE_A,
		pad_cfg.trap_dest == ROUTE_C, pad_cfg.trap_dest == ROUTE_B,
		pad_cfg.trap_dest == ROUTE_A,
		3'b000,
		pad_cfg.xtal_dest == ROUTE_C, pad_cfg.xtal_dest == ROUTE_B,
		pad_cfg.xtal_dest == ROUTE_A,
		pad_cfg.rcosc_dest == ROUTE_C, pad_cfg.rcosc_dest == ROUTE_B,
		pad_cfg.rcosc_dest == ROUTE_A,
		pad_cfg.comp_dest == ROUTE_B, pad_cfg.comp_dest == ROUTE_A
	};

	// Monitor signal fanned out over its pad group
	assign mon_val = {
		{2{mon.overtemp}},
		{3{mon.trap}},
		3'b000,
		{3{mon.xtal_in}},
		{3{mon.rcosc_in}},
		{2{mon.comp_in}}
	};

	// Whole group released to the registers only when its monitor is off
	// Comp on ROUTE_C still claims pads 0 and 1
	assign grp_keep = {
		{2{pad_cfg.overtemp_dest == ROUTE_OFF}},
		{3{pad_cfg.trap_dest == ROUTE_OFF}},
		3'b111,
		{3{pad_cfg.xtal_dest == ROUTE_OFF}},
		{3{pad_cfg.rcosc_dest == ROUTE_OFF}},
		{2{pad_cfg.comp_dest == ROUTE_OFF}}
	};

	assign gpio_out = (mon_sel & mon_val) | (~mon_sel & pad_cfg.data);
	// Claimed pads are driven, no pulls
	assign gpio_outenb = pad_cfg.oeb & grp_keep;
	assign gpio_pullup = pad_cfg.pu & grp_keep;
	assign gpio_pulldown = pad_cfg.pd & grp_keep;

endmodule

`default_nettype wire

// File: verilog/raven_io_top.sv
`default_nettype none

module raven_io_top
	import soc_map_pkg::*;
	import pad_cfg_pkg::*;
#(
	// Scratchpad size in words
	parameter integer MEM_WORDS = 1024
) (
	input wire clk,
	input wire resetn,
	// CPU native bus
	input wire mem_req_t mem_req,
	output mem_rsp_t mem_rsp,
	// External SRAM pins
	output logic ram_wenb,
	output logic [$clog2(MEM_WORDS)-1:0] ram_addr,
	output word_t ram_wdata,
	input wire word_t ram_rdata,
	// Pads
	input wire pad_word_t gpio_in,
	output pad_word_t gpio_out,
	output pad_word_t gpio_outenb,
	output pad_word_t gpio_pullup,
	output pad_word_t gpio_pulldown,
	// Analog macros
	input wire analog_mon_t mon,
	input wire spi_ro_t spi_ro,
	output analog_ctrl_t analog_ctrl,
	// Interrupts
	input wire irq_pin,
	input wire irq_spi,
	output word_t irq
);

	mem_req_t io_req;
	mem_rsp_t io_rsp;
	pad_cfg_t pad_cfg;

	// Window decode and SRAM side
	mem_bus_router #(
		.MEM_WORDS(MEM_WORDS)
	) u_router (
		.clk(clk),
		.resetn(resetn),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp),
		.io_req(io_req),
		.io_rsp(io_rsp),
		.ram_wenb(ram_wenb),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata)
	);

	// Control registers at IO_BASE
	io_ctrl_regs u_regs (
		.clk(clk),
		.resetn(resetn),
		.io_req(io_req),
		.io_rsp(io_rsp),
		.gpio_in(gpio_in),
		.gpio_out(gpio_out),
		.mon(mon),
		.spi_ro(spi_ro),
		.pad_cfg(pad_cfg),
		.analog_ctrl(analog_ctrl)
	);

	// Pad drive, fed back for GPIO_DATA readback
	pad_mux u_pad_mux (
		.pad_cfg(pad_cfg),
		.mon(mon),
		.gpio_out(gpio_out),
		.gpio_outenb(gpio_outenb),
		.gpio_pullup(gpio_pullup),
		.gpio_pulldown(gpio_pulldown)
	);

	irq_router u_irq (
		.pad_cfg(pad_cfg),
		.gpio_in(gpio_in),
		.mon(mon),
		.irq_pin(irq_pin),
		.irq_spi(irq_spi),
		.irq(irq)
	);

endmodule

`default_nettype wire

// File: verilog/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

	// One CPU data word
	typedef logic [31:0] word_t;

	// Byte write strobes, one per lane
	typedef logic [3:0] strb_t;

	// Native memory request
	// Held by the CPU until ready comes back
	typedef struct packed {
		logic valid;
		word_t addr;
		word_t wdata;
		strb_t wstrb;
	} mem_req_t;

	// Response, only meaningful in the ready cycle
	typedef struct packed {
		logic ready;
		word_t rdata;
	} mem_rsp_t;

	// Upper 24 address bits of the control window
	localparam logic [23:0] IO_BASE = 24'h030000;

	// Low address byte inside the control window
	typedef enum logic [7:0] {
		// GPIO block
		GPIO_DATA     = 8'h00,
		GPIO_OEB      = 8'h04,
		GPIO_PU       = 8'h08,
		GPIO_PD       = 8'h0c,
		// Comparator
		COMP_ENA      = 8'h60,
		COMP_NSRC     = 8'h64,
		COMP_PSRC     = 8'h68,
		COMP_DEST     = 8'h6c,
		// RC oscillator
		RCOSC_ENA     = 8'h70,
		RCOSC_DEST    = 8'h74,
		// Read-only words from the standalone SPI
		SPI_CONFIG    = 8'h80,
		SPI_OSC       = 8'h84,
		SPI_PLL       = 8'h88,
		MFGR_ID       = 8'h8c,
		PROD_ID       = 8'h90,
		MASK_REV      = 8'h94,
		// Monitor routing and IRQ sources
		XTAL_DEST     = 8'ha0,
		TRAP_DEST     = 8'ha8,
		IRQ7_SRC      = 8'hb0,
		IRQ8_SRC      = 8'hb4,
		// Analog output path
		ANALOG_SEL    = 8'hc0,
		OPAMP_BIAS    = 8'hc4,
		OPAMP_ENA     = 8'hc8,
		BG_ENA        = 8'hd0,
		// Over-temperature alarm
		OVERTEMP_ENA  = 8'he0,
		OVERTEMP_IN   = 8'he4,
		OVERTEMP_DEST = 8'he8
	} reg_offset_e;

endpackage

`default_nettype wire
